//--- Bender.yml
package:
  name: adc_ctl

sources:
  - adc_ctl_pkg.sv
  - acq_cfg_if.sv
  - reg_bank.sv
  - seq_acquisition.sv
  - adc_mock.sv
  - af_mux.sv
  - adc_ctl_top.sv
  - target: test
    files:
      - tb_adc_ctl_sva.sv
      - tb_adc_ctl.sv

//--- acq_cfg_if.sv
//////////////////////////////////////////////////
// acquisition parameters from the register bank to
// the sequence controller and the mocked adc
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface acq_cfg_if;

  logic [adc_ctl_pkg::PRECHARGE_W-1:0] precharge_cnt;   // precharge length in clocks
  logic [adc_ctl_pkg::APERTURE_W-1:0]  aperture_cnt;    // sample length in clocks
  logic [adc_ctl_pkg::SEQ_N_W-1:0]     seq_n;           // last step index

  // one word per step
  logic [adc_ctl_pkg::SEQ_MAX-1:0][adc_ctl_pkg::SEQ_W-1:0] seq_word;

  modport regs (output precharge_cnt, aperture_cnt, seq_n, seq_word);
  modport seq  (input precharge_cnt, seq_n, seq_word);
  modport mock (input aperture_cnt);

endinterface

`default_nettype wire

//--- adc_ctl_pkg.sv
//////////////////////////////////////////////////
// shared widths, register map, mode codes and the
// output vector layout for the adc board controller
//////////////////////////////////////////////////

`default_nettype none

package adc_ctl_pkg;

  // bus
  localparam int DATA_W = 32;
  localparam int ADDR_W = 4;            // word address

  // acquisition parameter widths
  localparam int PRECHARGE_W = 24;
  localparam int APERTURE_W  = 32;
  localparam int SEQ_W       = 6;       // [3:0] azmux  [5:4] precharge switches
  localparam int SEQ_MAX     = 4;
  localparam int SEQ_N_W     = 2;       // holds steps minus one
  localparam int MODE_W      = 3;
  localparam int OUT_W       = 24;
  localparam int HW_FLAGS_W  = 4;

  //////////////////////////////////////////////////
  // register map, one word each
  localparam logic [ADDR_W-1:0] ADDR_MODE      = 4'd0;
  localparam logic [ADDR_W-1:0] ADDR_DIRECT    = 4'd1;
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 4'd2;   // read only
  localparam logic [ADDR_W-1:0] ADDR_PRECHARGE = 4'd3;
  localparam logic [ADDR_W-1:0] ADDR_APERTURE  = 4'd4;
  localparam logic [ADDR_W-1:0] ADDR_SEQ_N     = 4'd5;
  localparam logic [ADDR_W-1:0] ADDR_SEQ0      = 4'd6;
  localparam logic [ADDR_W-1:0] ADDR_SEQ1      = 4'd7;
  localparam logic [ADDR_W-1:0] ADDR_SEQ2      = 4'd8;
  localparam logic [ADDR_W-1:0] ADDR_SEQ3      = 4'd9;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;           // status [7:0], hw flags above

  // alternate function modes, 5..7 give zeros
  localparam logic [MODE_W-1:0] MODE_DIRECT  = 3'd0;
  localparam logic [MODE_W-1:0] MODE_LO      = 3'd1;
  localparam logic [MODE_W-1:0] MODE_HI      = 3'd2;
  localparam logic [MODE_W-1:0] MODE_PATTERN = 3'd3;
  localparam logic [MODE_W-1:0] MODE_AZ_TEST = 3'd4;

  //////////////////////////////////////////////////
  // output vector, msb first
  typedef struct packed {
    logic       meas_complete;    // 23
    logic       cmpr_latch;       // 22
    logic [3:0] adc_refmux;       // 21..18
    logic [3:0] azmux;            // 17..14
    logic [1:0] pc_sw;            // 13..12
    logic [7:0] monitor;          // 11..4
    logic [3:0] leds;             // 3..0
  } out_vec_t;

endpackage

`default_nettype wire

//--- adc_ctl_top.sv
//////////////////////////////////////////////////
// controller top, joins the register bank, sequencer,
// mocked adc and output selector and drives the pins
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module adc_ctl_top (
  input  wire logic                               clk,
  input  wire logic                               arst_n_i,

  // wishbone classic slave
  input  wire logic                               wb_cyc_i,
  input  wire logic                               wb_stb_i,
  input  wire logic                               wb_we_i,
  input  wire logic [adc_ctl_pkg::ADDR_W-1:0]     wb_adr_i,
  input  wire logic [adc_ctl_pkg::DATA_W-1:0]     wb_dat_i,
  output      logic [adc_ctl_pkg::DATA_W-1:0]     wb_dat_o,
  output      logic                               wb_ack_o,

  input  wire logic                               trigger_i,
  input  wire logic [adc_ctl_pkg::HW_FLAGS_W-1:0] hw_flags_i,

  // board pins
  output      logic [3:0]                         leds_o,
  output      logic [7:0]                         monitor_o,
  output      logic [1:0]                         pc_sw_o,
  output      logic [3:0]                         azmux_o,
  output      logic [3:0]                         adc_refmux_o,
  output      logic                               adc_cmpr_latch_ctl_o,
  output      logic                               meas_complete_o
);

  logic [adc_ctl_pkg::MODE_W-1:0] mode;
  adc_ctl_pkg::out_vec_t          direct;
  adc_ctl_pkg::out_vec_t          seq_out;
  adc_ctl_pkg::out_vec_t          out_vec;
  logic                           adc_reset_n;      // sequencer to mock adc
  logic                           measure_valid;    // mock adc back to sequencer

  acq_cfg_if cfg_if ();

  reg_bank u_reg_bank (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .hw_flags_i (hw_flags_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .mode_o     (mode),
    .direct_o   (direct),
    .cfg        (cfg_if.regs)
  );

  seq_acquisition u_seq (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .trigger_i       (trigger_i),
    .measure_valid_i (measure_valid),
    .adc_reset_n_o   (adc_reset_n),
    .seq_out_o       (seq_out),
    .cfg             (cfg_if.seq)
  );

  adc_mock u_adc_mock (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .adc_reset_n_i   (adc_reset_n),
    .measure_valid_o (measure_valid),
    .cfg             (cfg_if.mock)
  );

  af_mux u_af_mux (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .mode_i   (mode),
    .direct_i (direct),
    .seq_i    (seq_out),
    .out_o    (out_vec)
  );

  //////////////////////////////////////////////////
  // vector fields out to the pins
  assign leds_o               = out_vec.leds;
  assign monitor_o            = out_vec.monitor;
  assign pc_sw_o              = out_vec.pc_sw;
  assign azmux_o              = out_vec.azmux;
  assign adc_refmux_o         = out_vec.adc_refmux;
  assign adc_cmpr_latch_ctl_o = out_vec.cmpr_latch;
  assign meas_complete_o      = out_vec.meas_complete;

endmodule

`default_nettype wire

//--- adc_mock.sv
//////////////////////////////////////////////////
// stand in for the adc, ends each sample after the
// programmed aperture with a single valid pulse
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module adc_mock (
  input  wire logic clk,
  input  wire logic arst_n_i,
  input  wire logic adc_reset_n_i,
  output      logic measure_valid_o,
  acq_cfg_if.mock   cfg
);

  logic [adc_ctl_pkg::APERTURE_W-1:0] cnt_q;
  logic [adc_ctl_pkg::APERTURE_W-1:0] cnt_nxt;
  logic [adc_ctl_pkg::APERTURE_W-1:0] aperture;
  logic                               done_q;    // quiet until reset again
  logic                               valid_q;

  assign aperture = (cfg.aperture_cnt == '0) ? 1 : cfg.aperture_cnt;   // 0 runs as 1
  assign cnt_nxt  = cnt_q + 1'b1;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= '0;
      done_q  <= 1'b0;
      valid_q <= 1'b0;
    end else if (!adc_reset_n_i) begin          // held in reset by the sequencer
      cnt_q   <= '0;
      done_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!done_q) begin
        cnt_q <= cnt_nxt;
        if (cnt_nxt == aperture) begin
          valid_q <= 1'b1;
          done_q  <= 1'b1;
        end
      end
    end
  end

  // an aborted conversion gives no result
  assign measure_valid_o = valid_q && adc_reset_n_i;

endmodule

`default_nettype wire

//--- af_mux.sv
//////////////////////////////////////////////////
// alternate function selector, picks the source of
// the output vector by mode and registers it
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module af_mux (
  input  wire logic                           clk,
  input  wire logic                           arst_n_i,
  input  wire logic [adc_ctl_pkg::MODE_W-1:0] mode_i,
  input  wire adc_ctl_pkg::out_vec_t          direct_i,
  input  wire adc_ctl_pkg::out_vec_t          seq_i,
  output      adc_ctl_pkg::out_vec_t          out_o
);

  logic [adc_ctl_pkg::OUT_W-1:0] pattern_q;   // free running test pattern
  adc_ctl_pkg::out_vec_t         sel;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pattern_q <= '0;
    end else begin
      pattern_q <= pattern_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // mode select
  always_comb begin
    case (mode_i)
      adc_ctl_pkg::MODE_DIRECT:  sel = direct_i;     // register driven
      adc_ctl_pkg::MODE_LO:      sel = '0;
      adc_ctl_pkg::MODE_HI:      sel = '1;
      adc_ctl_pkg::MODE_PATTERN: sel = pattern_q;    // needs a running clock
      adc_ctl_pkg::MODE_AZ_TEST: sel = seq_i;        // sequencer with mocked adc
      default:                   sel = '0;           // unused modes stay low
    endcase
  end

  // one cycle from source to pins
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_o <= '0;
    end else begin
      out_o <= sel;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
adc_ctl_pkg.sv
acq_cfg_if.sv
reg_bank.sv
seq_acquisition.sv
adc_mock.sv
af_mux.sv
adc_ctl_top.sv
tb_adc_ctl_sva.sv
tb_adc_ctl.sv

//--- reg_bank.sv
//////////////////////////////////////////////////
// wishbone classic slave with the control and
// acquisition registers, plus the read only status
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module reg_bank (
  input  wire logic                                    clk,
  input  wire logic                                    arst_n_i,
  input  wire logic                                    wb_cyc_i,
  input  wire logic                                    wb_stb_i,
  input  wire logic                                    wb_we_i,
  input  wire logic [adc_ctl_pkg::ADDR_W-1:0]          wb_adr_i,
  input  wire logic [adc_ctl_pkg::DATA_W-1:0]          wb_dat_i,
  input  wire logic [adc_ctl_pkg::HW_FLAGS_W-1:0]      hw_flags_i,
  output      logic [adc_ctl_pkg::DATA_W-1:0]          wb_dat_o,
  output      logic                                    wb_ack_o,
  output      logic [adc_ctl_pkg::MODE_W-1:0]          mode_o,
  output      adc_ctl_pkg::out_vec_t                   direct_o,
  acq_cfg_if.regs                                      cfg
);

  logic                              access;     // new cycle seen this edge
  logic                              wr_en;
  logic [adc_ctl_pkg::DATA_W-1:0]    rd_data;

  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;   // no wait states
  assign wr_en  = access && wb_we_i;

  //////////////////////////////////////////////////
  // read mux
  always_comb begin
    rd_data = '0;                                 // unmapped reads zero
    case (wb_adr_i)
      adc_ctl_pkg::ADDR_MODE:      rd_data[adc_ctl_pkg::MODE_W-1:0]      = mode_o;
      adc_ctl_pkg::ADDR_DIRECT:    rd_data[adc_ctl_pkg::OUT_W-1:0]       = direct_o;
      adc_ctl_pkg::ADDR_STATUS: begin
        rd_data[7:0]                            = adc_ctl_pkg::STATUS_MAGIC;
        rd_data[8 +: adc_ctl_pkg::HW_FLAGS_W]   = hw_flags_i;
      end
      adc_ctl_pkg::ADDR_PRECHARGE: rd_data[adc_ctl_pkg::PRECHARGE_W-1:0] = cfg.precharge_cnt;
      adc_ctl_pkg::ADDR_APERTURE:  rd_data                               = cfg.aperture_cnt;
      adc_ctl_pkg::ADDR_SEQ_N:     rd_data[adc_ctl_pkg::SEQ_N_W-1:0]     = cfg.seq_n;
      adc_ctl_pkg::ADDR_SEQ0:      rd_data[adc_ctl_pkg::SEQ_W-1:0]       = cfg.seq_word[0];
      adc_ctl_pkg::ADDR_SEQ1:      rd_data[adc_ctl_pkg::SEQ_W-1:0]       = cfg.seq_word[1];
      adc_ctl_pkg::ADDR_SEQ2:      rd_data[adc_ctl_pkg::SEQ_W-1:0]       = cfg.seq_word[2];
      adc_ctl_pkg::ADDR_SEQ3:      rd_data[adc_ctl_pkg::SEQ_W-1:0]       = cfg.seq_word[3];
      default:                     rd_data = '0;
    endcase
  end

  // single cycle ack with its read data
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= access;                         // drops on the following edge
      if (access) begin
        wb_dat_o <= rd_data;                      // valid together with ack
      end
    end
  end

  //////////////////////////////////////////////////
  // register writes take effect on the ack edge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_o            <= adc_ctl_pkg::MODE_DIRECT;
      direct_o          <= '0;
      cfg.precharge_cnt <= '0;
      cfg.aperture_cnt  <= '0;
      cfg.seq_n         <= '0;
      cfg.seq_word      <= '0;
    end else if (wr_en) begin
      case (wb_adr_i)
        adc_ctl_pkg::ADDR_MODE:      mode_o            <= wb_dat_i[adc_ctl_pkg::MODE_W-1:0];
        adc_ctl_pkg::ADDR_DIRECT:    direct_o          <= wb_dat_i[adc_ctl_pkg::OUT_W-1:0];
        adc_ctl_pkg::ADDR_PRECHARGE: cfg.precharge_cnt <= wb_dat_i[adc_ctl_pkg::PRECHARGE_W-1:0];
        adc_ctl_pkg::ADDR_APERTURE:  cfg.aperture_cnt  <= wb_dat_i;
        adc_ctl_pkg::ADDR_SEQ_N:     cfg.seq_n         <= wb_dat_i[adc_ctl_pkg::SEQ_N_W-1:0];
        adc_ctl_pkg::ADDR_SEQ0:      cfg.seq_word[0]   <= wb_dat_i[adc_ctl_pkg::SEQ_W-1:0];
        adc_ctl_pkg::ADDR_SEQ1:      cfg.seq_word[1]   <= wb_dat_i[adc_ctl_pkg::SEQ_W-1:0];
        adc_ctl_pkg::ADDR_SEQ2:      cfg.seq_word[2]   <= wb_dat_i[adc_ctl_pkg::SEQ_W-1:0];
        adc_ctl_pkg::ADDR_SEQ3:      cfg.seq_word[3]   <= wb_dat_i[adc_ctl_pkg::SEQ_W-1:0];
        default: ;                                // status and holes ignore writes
      endcase
    end
  end

endmodule

`default_nettype wire

//--- seq_acquisition.sv
//////////////////////////////////////////////////
// auto-zero sequence controller, steps through the
// programmed azmux/precharge words while trigger high
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module seq_acquisition (
  input  wire logic          clk,
  input  wire logic          arst_n_i,
  input  wire logic          trigger_i,
  input  wire logic          measure_valid_i,
  output      logic          adc_reset_n_o,
  output      adc_ctl_pkg::out_vec_t seq_out_o,
  acq_cfg_if.seq             cfg
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRECHARGE,
    ST_SAMPLE
  } state_t;

  state_t                                state_q;
  logic                                  trig_q1, trig_q2;    // synchronizer
  logic [adc_ctl_pkg::SEQ_N_W-1:0]       step_q;
  logic [adc_ctl_pkg::PRECHARGE_W-1:0]   pc_cnt_q;            // counts down to zero
  logic [adc_ctl_pkg::PRECHARGE_W-1:0]   pc_load;
  logic                                  complete_q;          // one cycle per sequence
  logic                                  led_q;
  logic [adc_ctl_pkg::SEQ_W-1:0]         word;

  // zero length precharge runs as one clock
  assign pc_load = (cfg.precharge_cnt == '0) ? '0 : cfg.precharge_cnt - 1'b1;
  assign word    = cfg.seq_word[step_q];

  //////////////////////////////////////////////////
  // trigger synchronizer
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_q1 <= 1'b0;
      trig_q2 <= 1'b0;
    end else begin
      trig_q1 <= trigger_i;
      trig_q2 <= trig_q1;
    end
  end

  //////////////////////////////////////////////////
  // step fsm
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ST_IDLE;
      step_q     <= '0;
      pc_cnt_q   <= '0;
      complete_q <= 1'b0;
      led_q      <= 1'b0;
    end else if (!trig_q2) begin                 // trigger gone so park in idle
      state_q    <= ST_IDLE;
      step_q     <= '0;
      pc_cnt_q   <= '0;
      complete_q <= 1'b0;
      led_q      <= 1'b0;
    end else begin
      complete_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          state_q  <= ST_PRECHARGE;               // step 0
          pc_cnt_q <= pc_load;
        end
        ST_PRECHARGE: begin
          if (pc_cnt_q == '0) state_q <= ST_SAMPLE;
          else                pc_cnt_q <= pc_cnt_q - 1'b1;
        end
        ST_SAMPLE: begin
          if (measure_valid_i) begin
            state_q  <= ST_PRECHARGE;
            pc_cnt_q <= pc_load;
            if (step_q == cfg.seq_n) begin        // last step done
              step_q     <= '0;
              complete_q <= 1'b1;
              led_q      <= !led_q;
            end else begin
              step_q <= step_q + 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign adc_reset_n_o = (state_q == ST_SAMPLE);  // adc runs only in sample phase

  //////////////////////////////////////////////////
  // output fields
  always_comb begin
    seq_out_o               = '0;
    seq_out_o.meas_complete = complete_q;
    seq_out_o.leds[0]       = led_q;
    seq_out_o.monitor[1:0]  = step_q;
    seq_out_o.monitor[2]    = (state_q == ST_SAMPLE);
    seq_out_o.monitor[3]    = adc_reset_n_o;
    seq_out_o.monitor[4]    = measure_valid_i;
    if (state_q != ST_IDLE) begin
      seq_out_o.azmux = word[3:0];                // held through both phases
    end
    if (state_q == ST_SAMPLE) begin
      seq_out_o.pc_sw = word[5:4];                // precharge switches off in precharge
    end
  end

endmodule

`default_nettype wire

//--- tb_adc_ctl.sv
//////////////////////////////////////////////////
// directed testbench for the controller top, runs
// register, mode, pattern and az sequence tests
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_adc_ctl;

  localparam int CLK_PERIOD    = 8;
  localparam int ACK_TIMEOUT   = 16;     // cycles to wait for ack
  localparam int PULSE_TIMEOUT = 200;    // generous bound per az sequence
  localparam int SEQ_PULSES    = 3;
  localparam int N_TRANSFERS   = 48;     // upper bound over all tests
  // reset, bus traffic, pattern run, az sequences, trigger release
  localparam int WATCH_CYCLES  = 8 + N_TRANSFERS * (ACK_TIMEOUT + 2) + 24 +
                                 PULSE_TIMEOUT * (SEQ_PULSES + 1) + 60;

  logic        clk;
  logic        arst_n_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [3:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        trigger_i;
  logic [3:0]  hw_flags_i;
  logic [3:0]  leds_o;
  logic [7:0]  monitor_o;
  logic [1:0]  pc_sw_o;
  logic [3:0]  azmux_o;
  logic [3:0]  adc_refmux_o;
  logic        adc_cmpr_latch_ctl_o;
  logic        meas_complete_o;

  adc_ctl_pkg::out_vec_t pins;          // pins put back together
  logic [5:0]            seq_words [4]; // programmed step words
  int                    seed;
  int                    errors = 0;
  int                    checks = 0;

  assign pins = {meas_complete_o, adc_cmpr_latch_ctl_o, adc_refmux_o, azmux_o,
                 pc_sw_o, monitor_o, leds_o};

  adc_ctl_top UUT (
    .clk                  (clk),
    .arst_n_i             (arst_n_i),
    .wb_cyc_i             (wb_cyc_i),
    .wb_stb_i             (wb_stb_i),
    .wb_we_i              (wb_we_i),
    .wb_adr_i             (wb_adr_i),
    .wb_dat_i             (wb_dat_i),
    .wb_dat_o             (wb_dat_o),
    .wb_ack_o             (wb_ack_o),
    .trigger_i            (trigger_i),
    .hw_flags_i           (hw_flags_i),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .adc_refmux_o         (adc_refmux_o),
    .adc_cmpr_latch_ctl_o (adc_cmpr_latch_ctl_o),
    .meas_complete_o      (meas_complete_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run stopped", WATCH_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // helpers
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] width_mask(input int w);
    if (w >= 32) return '1;
    return (32'd1 << w) - 32'd1;
  endfunction

  // register widths from the register map
  function automatic int reg_width(input logic [3:0] addr);
    case (addr)
      adc_ctl_pkg::ADDR_MODE:      return adc_ctl_pkg::MODE_W;
      adc_ctl_pkg::ADDR_DIRECT:    return adc_ctl_pkg::OUT_W;
      adc_ctl_pkg::ADDR_PRECHARGE: return adc_ctl_pkg::PRECHARGE_W;
      adc_ctl_pkg::ADDR_APERTURE:  return adc_ctl_pkg::APERTURE_W;
      adc_ctl_pkg::ADDR_SEQ_N:     return adc_ctl_pkg::SEQ_N_W;
      default:                     return adc_ctl_pkg::SEQ_W;   // seq0..3
    endcase
  endfunction

  // one classic cycle held until ack and sampled on the falling edge
  task automatic bus_transfer(input logic we, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int wait_cycles;
    @(posedge clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= addr;
    wb_dat_i <= wdata;
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!wb_ack_o && wait_cycles < ACK_TIMEOUT);
    if (!wb_ack_o) begin
      errors++;
      $display("no ack within %0d cycles for access to address %0d", ACK_TIMEOUT, addr);
    end
    rdata = wb_dat_o;
    @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
    bus_transfer(1'b0, addr, 32'd0, data);
  endtask

  task automatic print_result(input string name, input int start_errs);
    if (errors == start_errs) $display("%-16s passed", name);
    else $display("%-16s %0d errors", name, errors - start_errs);
  endtask

  //////////////////////////////////////////////////
  // tests
  task automatic register_access_test();
    int          start_errs;
    int          i;
    logic [31:0] data [10];
    logic [31:0] rdata;
    logic [3:0]  flags;
    start_errs = errors;
    @(negedge clk);
    compare_value("pins after reset", pins, 32'd0);
    compare_value("wb_ack_o after reset", wb_ack_o, 32'd0);
    for (i = 0; i < 10; i++) begin
      data[i] = $random(seed);
      if (i != adc_ctl_pkg::ADDR_STATUS) wb_write(4'(i), data[i]);
    end
    for (i = 0; i < 10; i++) begin
      if (i != adc_ctl_pkg::ADDR_STATUS) begin
        wb_read(4'(i), rdata);
        compare_value($sformatf("wb_dat_o addr %0d", i), rdata,
                      data[i] & width_mask(reg_width(4'(i))));
      end
    end
    flags = 4'($random(seed));
    @(posedge clk);
    hw_flags_i <= flags;
    wb_write(adc_ctl_pkg::ADDR_STATUS, 32'hFFFF_FFFF);    // read only so the write is dropped
    wb_read(adc_ctl_pkg::ADDR_STATUS, rdata);
    compare_value("wb_dat_o status", rdata, {20'd0, flags, adc_ctl_pkg::STATUS_MAGIC});
    wb_read(4'hF, rdata);
    compare_value("wb_dat_o unmapped", rdata, 32'd0);
    print_result("register access", start_errs);
  endtask

  task automatic static_modes_test();
    int          start_errs;
    logic [31:0] direct;
    start_errs = errors;
    direct = $random(seed);
    wb_write(adc_ctl_pkg::ADDR_DIRECT, direct);
    wb_write(adc_ctl_pkg::ADDR_MODE, 32'(adc_ctl_pkg::MODE_DIRECT));
    @(negedge clk);
    compare_value("pins direct", pins, direct & width_mask(adc_ctl_pkg::OUT_W));
    wb_write(adc_ctl_pkg::ADDR_MODE, 32'(adc_ctl_pkg::MODE_LO));
    @(negedge clk);
    compare_value("pins lo", pins, 32'd0);
    wb_write(adc_ctl_pkg::ADDR_MODE, 32'(adc_ctl_pkg::MODE_HI));
    @(negedge clk);
    compare_value("pins hi", pins, width_mask(adc_ctl_pkg::OUT_W));
    wb_write(adc_ctl_pkg::ADDR_MODE, 32'd6);              // unused mode
    @(negedge clk);
    compare_value("pins mode 6", pins, 32'd0);
    print_result("static modes", start_errs);
  endtask

  task automatic pattern_mode_test();
    int         start_errs;
    int         i;
    logic [23:0] prev;
    start_errs = errors;
    wb_write(adc_ctl_pkg::ADDR_MODE, 32'(adc_ctl_pkg::MODE_PATTERN));
    @(negedge clk);
    prev = pins;
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      compare_value("pins pattern", pins, 32'(24'(prev + 24'd1)));   // wraps at 24 bits
      prev = pins;
    end
    print_result("pattern mode", start_errs);
  endtask

  task automatic az_sequence_test();
    int          start_errs;
    int          i;
    int          cycles;
    int          pulses;
    int          step;
    int          last_step;
    int          pc_cnt;
    int          pc_len;
    logic        led;
    logic [31:0] r;
    start_errs = errors;
    wb_write(adc_ctl_pkg::ADDR_SEQ_N, 32'd2);             // three steps
    for (i = 0; i < adc_ctl_pkg::SEQ_MAX; i++) begin
      r = $random(seed);
      seq_words[i] = r[5:0];
      wb_write(adc_ctl_pkg::ADDR_SEQ0 + 4'(i), {26'd0, r[5:0]});
    end
    r = $random(seed);
    pc_cnt = 1 + r[1:0];                                  // 1..4 clocks
    wb_write(adc_ctl_pkg::ADDR_PRECHARGE, 32'(pc_cnt));
    wb_write(adc_ctl_pkg::ADDR_APERTURE, 32'd1 + r[4:2]);    // 1..8 clocks
    wb_write(adc_ctl_pkg::ADDR_MODE, 32'(adc_ctl_pkg::MODE_AZ_TEST));
    @(posedge clk);
    trigger_i <= 1'b1;
    cycles = 0;
    do begin                                              // sync to a sequence end
      @(negedge clk);
      cycles++;
    end while (!meas_complete_o && cycles < PULSE_TIMEOUT);
    if (!meas_complete_o) begin
      errors++;
      $display("no meas_complete pulse within %0d cycles of the trigger", PULSE_TIMEOUT);
    end else begin
      led       = leds_o[0];
      last_step = monitor_o[1:0];
      pc_len    = 1;                                      // pulse opens the step 0 precharge
      pulses    = 0;
      cycles    = 0;
      while (pulses < SEQ_PULSES && cycles < PULSE_TIMEOUT * SEQ_PULSES) begin
        @(negedge clk);
        cycles++;
        step = monitor_o[1:0];
        // precharge length counted up to the first sample cycle
        if (monitor_o[2]) begin
          if (pc_len != 0) compare_value("precharge cycles", pc_len, pc_cnt);
          pc_len = 0;
        end else begin
          pc_len++;
        end
        if (meas_complete_o) begin
          compare_value("precharge at sequence end", pc_len, 32'd1);
          compare_value("step before pulse", last_step, 32'd2);
          compare_value("monitor_o step", step, 32'd0);
          compare_value("leds_o[0]", leds_o[0], !led);    // toggles per sequence
          led = leds_o[0];
          pulses++;
        end else begin
          if (step != last_step) compare_value("monitor_o step", step, last_step + 1);
          compare_value("leds_o[0]", leds_o[0], led);
        end
        last_step = step;
        compare_value("azmux_o", azmux_o, seq_words[step][3:0]);
        // switches open in precharge and carry the step bits in sample
        compare_value("pc_sw_o", pc_sw_o, monitor_o[2] ? seq_words[step][5:4] : 2'b00);
      end
      if (pulses < SEQ_PULSES) begin
        errors++;
        $display("only %0d of %0d az sequences completed", pulses, SEQ_PULSES);
      end
    end
    print_result("az sequence", start_errs);
  endtask

  task automatic trigger_release_test();
    int start_errs;
    int i;
    start_errs = errors;
    @(posedge clk);
    trigger_i <= 1'b0;
    repeat (4) @(posedge clk);                            // synchronizer and pin register
    for (i = 0; i < 50; i++) begin
      @(negedge clk);
      compare_value("azmux_o idle", azmux_o, 32'd0);
      compare_value("pc_sw_o idle", pc_sw_o, 32'd0);
      compare_value("meas_complete_o idle", meas_complete_o, 32'd0);
    end
    print_result("trigger release", start_errs);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    seed       = 85157;
    arst_n_i   = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    trigger_i  = 1'b0;
    hw_flags_i = '0;
    repeat (4) @(posedge clk);
    arst_n_i <= 1'b1;
    register_access_test();
    static_modes_test();
    pattern_mode_test();
    az_sequence_test();
    trigger_release_test();
    errors = errors + int'(UUT.u_sva.assert_fails);      // bound assertion failures
    $display("5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_adc_ctl_sva.sv
//////////////////////////////////////////////////
// bus and pulse rules of the controller, bound into
// the top level by the bind at the end of this file
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_adc_ctl_sva (
  input wire logic                           clk,
  input wire logic                           arst_n_i,
  input wire logic                           wb_cyc_i,
  input wire logic                           wb_stb_i,
  input wire logic                           wb_ack_i,
  input wire logic                           meas_complete_i,
  input wire logic [adc_ctl_pkg::MODE_W-1:0] mode_i,
  input wire logic                           adc_reset_n_i,
  input wire logic                           measure_valid_i
);

  int unsigned assert_fails = 0;    // failed assertions so far

  // ack is a single cycle strobe
  ack_single: assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("wb_ack_o high for two cycles in a row");
      assert_fails++;
    end

  // no ack without a request on the previous edge
  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
    else begin
      $error("wb_ack_o rose without cyc and stb");
      assert_fails++;
    end

  // the pin only follows the sequencer while the az mode is on for two edges
  complete_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    (meas_complete_i && mode_i == adc_ctl_pkg::MODE_AZ_TEST &&
     $past(mode_i) == adc_ctl_pkg::MODE_AZ_TEST) |=> !meas_complete_i)
    else begin
      $error("meas_complete_o longer than one cycle");
      assert_fails++;
    end

  // a valid pulse needs the adc released since the edge before
  valid_in_sample: assert property (@(posedge clk) disable iff (!arst_n_i)
    measure_valid_i |-> $past(adc_reset_n_i))
    else begin
      $error("measure_valid high while the adc is held in reset");
      assert_fails++;
    end

endmodule

bind adc_ctl_top tb_adc_ctl_sva u_sva (
  .clk             (clk),
  .arst_n_i        (arst_n_i),
  .wb_cyc_i        (wb_cyc_i),
  .wb_stb_i        (wb_stb_i),
  .wb_ack_i        (wb_ack_o),
  .meas_complete_i (meas_complete_o),
  .mode_i          (mode),
  .adc_reset_n_i   (adc_reset_n),
  .measure_valid_i (measure_valid)
);

`default_nettype wire
